//--- include/dcache_cfg.svh
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// associativity of the cache.
`define DCACHE_WAYS 4

// number of sets, gives a 6-bit index.
`define DCACHE_SETS 64

// request queue depth, equal to the core's starting credits.
`define DCACHE_REQ_CREDITS 2

// anything above this is device space and bypasses the cache.
`define DCACHE_CACHEABLE_LIMIT 64'h8fff_ffff

`endif

//--- design/dcache_pkg.sv
`include "dcache_cfg.svh"

package dcache_pkg;

	localparam int OFFSET_W = 4; // 16-byte lines.
	localparam int INDEX_W = $clog2(`DCACHE_SETS);
	localparam int TAG_W = 64 - INDEX_W - OFFSET_W;

	typedef struct packed {
		logic [TAG_W-1:0] tag;
		logic [INDEX_W-1:0] index;
		logic [OFFSET_W-1:0] offset;
	} dcache_addr_fields_t;

	// one address word, seen raw or split for the arrays.
	typedef union packed {
		logic [63:0] raw;
		dcache_addr_fields_t fields;
	} dcache_addr_u;

	typedef struct packed {
		logic write;
		dcache_addr_u addr;
		logic [63:0] wdata;
		logic [7:0] strb;
	} dcache_req_t;

	typedef struct packed {
		dcache_req_t req;
		logic cacheable;
		logic hit;
		logic [`DCACHE_WAYS-1:0] hit_way; // one-hot, zero on miss.
		logic [`DCACHE_WAYS-1:0] victim_way; // one-hot.
	} dcache_lookup_t;

	typedef struct packed {
		logic valid;
		logic [INDEX_W-1:0] index;
		logic [TAG_W-1:0] tag;
		logic [`DCACHE_WAYS-1:0] way;
	} dcache_fill_t;

	typedef struct packed {
		logic write;
		logic [63:0] addr; // line aligned for reads.
		logic [63:0] wdata;
		logic [7:0] strb;
	} dcache_mem_req_t;

	typedef logic [127:0] dcache_line_t;

	typedef struct packed {
		logic write;
		logic [63:0] rdata;
	} dcache_rsp_t;

endpackage

//--- design/dcache_tag_lookup.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_tag_lookup (
	input  logic clk,
	input  logic rst,
	input  logic req_valid,
	input  dcache_pkg::dcache_req_t req,
	output logic req_credit,
	input  dcache_pkg::dcache_fill_t fill,
	output logic lookup_valid,
	output dcache_pkg::dcache_lookup_t lookup,
	input  logic lookup_ready
);
	import dcache_pkg::*;

	localparam int DEPTH = `DCACHE_REQ_CREDITS;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	dcache_req_t queue [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	logic [TAG_W-1:0] tag_mem [`DCACHE_WAYS][`DCACHE_SETS];
	logic [`DCACHE_SETS-1:0] valid_bits [`DCACHE_WAYS];
	logic [`DCACHE_WAYS-1:0] victim_ptr;
	logic miss_pending; // a line fetch is in execute, tags not final yet.

	dcache_req_t head;
	logic head_cacheable;
	logic [`DCACHE_WAYS-1:0] head_hit_way;
	logic lookup_take;
	logic lookup_is_fetch;
	logic deq;

	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign head = queue[rd_ptr];
	assign head_cacheable = head.addr.raw <= `DCACHE_CACHEABLE_LIMIT;

	// tag compare in all ways at once.
	always_comb begin
		for (int w = 0; w < `DCACHE_WAYS; w++) begin
			head_hit_way[w] = head_cacheable
				&& valid_bits[w][head.addr.fields.index]
				&& (tag_mem[w][head.addr.fields.index] == head.addr.fields.tag);
		end
	end

	assign lookup_take = lookup_valid && lookup_ready;
	assign lookup_is_fetch = lookup.cacheable && !lookup.hit && !lookup.req.write;

	// hold off while a fetch may still change the tags of any set.
	assign deq = (count != '0) && !miss_pending
		&& (!lookup_valid || (lookup_ready && !lookup_is_fetch));
	assign req_credit = deq; // one credit back per dequeue.

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			lookup_valid <= 1'b0;
			miss_pending <= 1'b0;
			victim_ptr <= `DCACHE_WAYS'(1); // way 0 first.
			for (int w = 0; w < `DCACHE_WAYS; w++) begin
				valid_bits[w] <= '0;
			end
		end else begin
			if (req_valid)
				wr_ptr <= ptr_next(wr_ptr);
			if (deq)
				rd_ptr <= ptr_next(rd_ptr);
			count <= count + CNT_W'(req_valid) - CNT_W'(deq);

			if (deq)
				lookup_valid <= 1'b1;
			else if (lookup_take)
				lookup_valid <= 1'b0;

			if (lookup_take && lookup_is_fetch)
				miss_pending <= 1'b1;
			else if (fill.valid)
				miss_pending <= 1'b0;

			if (fill.valid) begin
				victim_ptr <= {victim_ptr[`DCACHE_WAYS-2:0], victim_ptr[`DCACHE_WAYS-1]};
				for (int w = 0; w < `DCACHE_WAYS; w++) begin
					if (fill.way[w])
						valid_bits[w][fill.index] <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (req_valid)
			queue[wr_ptr] <= req;
		if (deq) begin
			lookup.req <= head;
			lookup.cacheable <= head_cacheable;
			lookup.hit <= |head_hit_way;
			lookup.hit_way <= head_hit_way;
			lookup.victim_way <= victim_ptr;
		end
		for (int w = 0; w < `DCACHE_WAYS; w++) begin
			if (fill.valid && fill.way[w])
				tag_mem[w][fill.index] <= fill.tag;
		end
	end

endmodule

//--- design/dcache_line_access.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_line_access (
	input  logic clk,
	input  logic rst,
	input  logic lookup_valid,
	input  dcache_pkg::dcache_lookup_t lookup,
	output logic lookup_ready,
	output dcache_pkg::dcache_fill_t fill,
	output logic mem_req_valid,
	output dcache_pkg::dcache_mem_req_t mem_req,
	input  logic mem_req_ready,
	input  logic mem_rsp_valid,
	input  dcache_pkg::dcache_line_t mem_rsp_line,
	output logic line_valid,
	output dcache_pkg::dcache_line_t line,
	output logic [3:0] line_offset,
	output logic line_write
);
	import dcache_pkg::*;

	typedef enum logic [1:0] {
		s_idle,
		s_mem_req,
		s_mem_wait,
		s_fill
	} state_t;

	state_t state;
	dcache_lookup_t cur; // access being executed.
	logic hit_rsp;
	dcache_line_t mem_line_q;
	dcache_line_t way_rd [`DCACHE_WAYS];
	dcache_line_t hit_line;
	dcache_line_t merged_line;
	dcache_line_t arr_wdata;
	logic [`DCACHE_WAYS-1:0] arr_we;
	logic [INDEX_W-1:0] cur_index;
	logic cur_fetch;
	logic cur_merge;
	logic accept;

	// byte-strobe merge of a 64-bit store into one half of a line.
	function automatic dcache_line_t merge_line(input dcache_line_t old, input logic upper,
		input logic [63:0] wdata, input logic [7:0] strb);
		dcache_line_t res;
		res = old;
		for (int b = 0; b < 8; b++) begin
			if (strb[b])
				res[(upper ? 64 : 0) + b * 8 +: 8] = wdata[b * 8 +: 8];
		end
		return res;
	endfunction

	assign lookup_ready = (state == s_idle); // also low during the fill cycle.
	assign accept = lookup_valid && lookup_ready;

	assign cur_index = cur.req.addr.fields.index;
	assign cur_fetch = cur.cacheable && !cur.req.write && !cur.hit;
	assign cur_merge = cur.req.write && cur.hit;

	// one data array per way, read on accept.
	for (genvar w = 0; w < `DCACHE_WAYS; w++) begin : g_way
		dcache_line_t data_mem [`DCACHE_SETS];

		always_ff @(posedge clk) begin
			if (arr_we[w])
				data_mem[cur_index] <= arr_wdata;
			if (accept)
				way_rd[w] <= data_mem[lookup.req.addr.fields.index];
		end
	end

	always_comb begin
		hit_line = '0;
		for (int w = 0; w < `DCACHE_WAYS; w++) begin
			if (cur.hit_way[w])
				hit_line = hit_line | way_rd[w];
		end
	end

	assign merged_line = merge_line(hit_line, cur.req.addr.fields.offset[3],
		cur.req.wdata, cur.req.strb);
	assign arr_wdata = cur_fetch ? mem_line_q : merged_line;
	assign arr_we = (state != s_fill) ? '0 :
		cur_fetch ? cur.victim_way :
		cur_merge ? cur.hit_way : '0;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= s_idle;
			hit_rsp <= 1'b0;
		end else begin
			hit_rsp <= 1'b0;
			case (state)
				s_idle: begin
					if (accept) begin
						if (lookup.hit && !lookup.req.write)
							hit_rsp <= 1'b1; // served from the arrays.
						else
							state <= s_mem_req;
					end
				end
				s_mem_req: if (mem_req_ready) state <= s_mem_wait;
				s_mem_wait: if (mem_rsp_valid) state <= s_fill;
				s_fill: state <= s_idle;
				default: state <= s_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			cur <= lookup;
		if (state == s_mem_wait && mem_rsp_valid)
			mem_line_q <= mem_rsp_line;
	end

	assign mem_req_valid = (state == s_mem_req);
	assign mem_req.write = cur.req.write;
	assign mem_req.addr = cur.req.write ? cur.req.addr.raw : {cur.req.addr.raw[63:4], 4'b0};
	assign mem_req.wdata = cur.req.wdata;
	assign mem_req.strb = cur.req.strb;

	// tag update for the decode stage, only for a line fetch.
	assign fill.valid = (state == s_fill) && cur_fetch;
	assign fill.index = cur_index;
	assign fill.tag = cur.req.addr.fields.tag;
	assign fill.way = cur.victim_way;

	assign line_valid = hit_rsp || (state == s_fill);
	assign line = hit_rsp ? hit_line : mem_line_q;
	assign line_offset = cur.req.addr.fields.offset;
	assign line_write = cur.req.write;

endmodule

//--- design/dcache_response.sv
`timescale 1ns/1ps

module dcache_response (
	input  logic line_valid,
	input  dcache_pkg::dcache_line_t line,
	input  logic [3:0] line_offset,
	input  logic line_write,
	output logic rsp_valid,
	output dcache_pkg::dcache_rsp_t rsp
);

	logic [63:0] half;

	// offset bit 3 picks the doubleword within the line.
	assign half = line_offset[3] ? line[127:64] : line[63:0];

	assign rsp_valid = line_valid;
	assign rsp.write = line_write;
	assign rsp.rdata = line_write ? 64'd0 : half; // writes only acknowledge.

endmodule

//--- design/dcache_top.sv
`timescale 1ns/1ps

module dcache_top (
	input  logic clk,
	input  logic rst,

	input  logic req_valid,
	input  dcache_pkg::dcache_req_t req,
	output logic req_credit,

	output logic rsp_valid,
	output dcache_pkg::dcache_rsp_t rsp,

	output logic mem_req_valid,
	output dcache_pkg::dcache_mem_req_t mem_req,
	input  logic mem_req_ready,
	input  logic mem_rsp_valid,
	input  dcache_pkg::dcache_line_t mem_rsp_line
);
	import dcache_pkg::*;

	logic lookup_valid;
	dcache_lookup_t lookup;
	logic lookup_ready;
	dcache_fill_t fill;

	logic line_valid;
	dcache_line_t line;
	logic [3:0] line_offset;
	logic line_write;

	// decode.
	dcache_tag_lookup tag_lookup_i (
		.clk          (clk),
		.rst          (rst),
		.req_valid    (req_valid),
		.req          (req),
		.req_credit   (req_credit),
		.fill         (fill),
		.lookup_valid (lookup_valid),
		.lookup       (lookup),
		.lookup_ready (lookup_ready)
	);

	// execute.
	dcache_line_access line_access_i (
		.clk           (clk),
		.rst           (rst),
		.lookup_valid  (lookup_valid),
		.lookup        (lookup),
		.lookup_ready  (lookup_ready),
		.fill          (fill),
		.mem_req_valid (mem_req_valid),
		.mem_req       (mem_req),
		.mem_req_ready (mem_req_ready),
		.mem_rsp_valid (mem_rsp_valid),
		.mem_rsp_line  (mem_rsp_line),
		.line_valid    (line_valid),
		.line          (line),
		.line_offset   (line_offset),
		.line_write    (line_write)
	);

	// result.
	dcache_response response_i (
		.line_valid  (line_valid),
		.line        (line),
		.line_offset (line_offset),
		.line_write  (line_write),
		.rsp_valid   (rsp_valid),
		.rsp         (rsp)
	);

endmodule

//--- verification/dcache_assertions.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_assertions (
	input  logic clk,
	input  logic rst,
	input  logic req_valid,
	input  logic req_credit,
	input  logic rsp_valid,
	input  logic mem_req_valid,
	input  logic mem_req_ready,
	input  dcache_pkg::dcache_mem_req_t mem_req,
	input  logic lookup_valid,
	input  dcache_pkg::dcache_lookup_t lookup
);
	import dcache_pkg::*;

	int in_queue; // requests sent but not yet credited back.

	always_ff @(posedge clk) begin
		if (rst)
			in_queue <= 0;
		else
			in_queue <= in_queue + int'(req_valid) - int'(req_credit);
	end

	a_mem_req_stable: assert property (@(posedge clk) disable iff (rst)
		mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
		else $error("mem_req changed while waiting for mem_req_ready");

	a_hit_way_onehot: assert property (@(posedge clk) disable iff (rst)
		lookup_valid |-> $onehot0(lookup.hit_way))
		else $error("lookup hit way has more than one bit set");

	a_queue_bound: assert property (@(posedge clk) disable iff (rst)
		in_queue <= `DCACHE_REQ_CREDITS)
		else $error("more requests queued than credits allow");

	a_rsp_valid_known: assert property (@(posedge clk) disable iff (rst)
		!$isunknown(rsp_valid))
		else $error("rsp_valid is unknown");

endmodule

bind dcache_top dcache_assertions assertions_i (
	.clk           (clk),
	.rst           (rst),
	.req_valid     (req_valid),
	.req_credit    (req_credit),
	.rsp_valid     (rsp_valid),
	.mem_req_valid (mem_req_valid),
	.mem_req_ready (mem_req_ready),
	.mem_req       (mem_req),
	.lookup_valid  (lookup_valid),
	.lookup        (lookup)
);

//--- verification/dcache_tb.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_tb;
	import dcache_pkg::*;

	localparam int TIMEOUT = 300; // cycles per wait.

	typedef struct packed {
		logic write;
		logic [63:0] addr;
		logic [63:0] data;
	} exp_rsp_t;

	logic clk = 1'b0;
	logic rst;
	logic req_valid;
	dcache_req_t req;
	logic req_credit;
	logic rsp_valid;
	dcache_rsp_t rsp;
	logic mem_req_valid;
	dcache_mem_req_t mem_req;
	logic mem_req_ready;
	logic mem_rsp_valid;
	dcache_line_t mem_rsp_line;

	integer seed;
	integer mem_seed;
	int errors = 0;
	int checks = 0;
	int credits;
	int credits_returned = 0;
	int line_reads = 0;
	exp_rsp_t exp_q [$];
	exp_rsp_t front;

	logic [63:0] mem_words [logic [60:0]]; // memory model, sparse.
	logic [63:0] ref_words [logic [60:0]]; // reference model.
	logic mem_pending;
	int mem_lat;
	dcache_line_t mem_line_q;
	dcache_mem_req_t last_mem_req;

	dcache_top dut_i (.*);

	always #20 clk = ~clk;

	// untouched memory holds a pattern of the whole word address.
	function automatic logic [63:0] fill_word(input logic [63:0] a);
		return a ^ {a[31:0], a[63:32]} ^ 64'h5a5a_0f0f_3c3c_9696;
	endfunction

	function automatic logic [63:0] merge_bytes(input logic [63:0] old, input logic [63:0] data,
		input logic [7:0] strb);
		logic [63:0] res;
		res = old;
		for (int b = 0; b < 8; b++) begin
			if (strb[b])
				res[b * 8 +: 8] = data[b * 8 +: 8];
		end
		return res;
	endfunction

	function automatic logic [63:0] mem_load(input logic [63:0] addr);
		return mem_words.exists(addr[63:3]) ? mem_words[addr[63:3]] : fill_word({addr[63:3], 3'b0});
	endfunction

	function automatic logic [63:0] ref_load(input logic [63:0] addr);
		return ref_words.exists(addr[63:3]) ? ref_words[addr[63:3]] : fill_word({addr[63:3], 3'b0});
	endfunction

	task automatic ref_store(input logic [63:0] addr, input logic [63:0] data,
		input logic [7:0] strb);
		ref_words[addr[63:3]] = merge_bytes(ref_load(addr), data, strb);
	endtask

	// changes memory behind the cache's back.
	task automatic backdoor_write(input logic [63:0] addr, input logic [63:0] data);
		mem_words[addr[63:3]] = data;
	endtask

	task automatic check(input string what, input logic [63:0] exp, input logic [63:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("[FAIL] %0t: %s expected %h got %h", $time, what, exp, act);
		end
	endtask

	task automatic abort(input string msg);
		errors++;
		$display("timeout at %0t: %s", $time, msg);
		$display("checks %0d, errors %0d", checks, errors);
		$display("CHECKS FAILED");
		$finish;
	endtask

	// memory model with random ready and 1 to 6 cycles of latency.
	always @(posedge clk) begin
		if (rst) begin
			mem_req_ready <= 1'b0;
			mem_rsp_valid <= 1'b0;
			mem_rsp_line <= '0;
			mem_pending <= 1'b0;
			mem_lat <= 0;
		end else begin
			mem_req_ready <= 1'($random(mem_seed));
			mem_rsp_valid <= 1'b0;
			if (mem_req_valid && mem_req_ready) begin
				mem_pending <= 1'b1;
				mem_lat <= 1 + {$random(mem_seed)} % 6;
				last_mem_req <= mem_req;
				if (mem_req.write) begin
					mem_words[mem_req.addr[63:3]] =
						merge_bytes(mem_load(mem_req.addr), mem_req.wdata, mem_req.strb);
					mem_line_q <= '0; // write ack carries no data.
				end else begin
					line_reads++;
					mem_line_q <= {mem_load(mem_req.addr | 64'h8), mem_load(mem_req.addr)};
				end
			end else if (mem_pending) begin
				if (mem_lat == 1) begin
					mem_pending <= 1'b0;
					mem_rsp_valid <= 1'b1;
					mem_rsp_line <= mem_line_q;
				end else begin
					mem_lat <= mem_lat - 1;
				end
			end
		end
	end

	// credits and responses are sampled mid-cycle.
	always @(negedge clk) begin
		if (!rst && req_credit) begin
			credits++;
			credits_returned++;
		end
		if (!rst && rsp_valid) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("response at %0t arrived with no request outstanding", $time);
			end else begin
				front = exp_q.pop_front();
				check($sformatf("write flag @%h", front.addr), 64'(front.write), 64'(rsp.write));
				check($sformatf("read data @%h", front.addr), front.data, rsp.rdata);
			end
		end
	end

	task automatic issue(input logic write, input logic [63:0] addr, input logic [63:0] wdata,
		input logic [7:0] strb);
		dcache_req_t r;
		int n;
		@(posedge clk);
		n = 0;
		while (credits == 0 && n < TIMEOUT) begin
			req_valid <= 1'b0;
			@(posedge clk);
			n++;
		end
		if (credits == 0) begin
			abort($sformatf("no credit came back to send a request to %h", addr));
		end else begin
			r.write = write;
			r.addr.raw = addr;
			r.wdata = wdata;
			r.strb = strb;
			req_valid <= 1'b1;
			req <= r;
			credits--;
			if (write) begin
				ref_store(addr, wdata, strb);
				exp_q.push_back({1'b1, addr, 64'd0});
			end else begin
				exp_q.push_back({1'b0, addr, ref_load(addr)});
			end
		end
	endtask

	task automatic drain(input string what);
		int n;
		@(posedge clk);
		req_valid <= 1'b0;
		n = 0;
		while (exp_q.size() != 0 && n < TIMEOUT) begin
			@(posedge clk);
			n++;
		end
		if (exp_q.size() != 0)
			abort($sformatf("%0d response(s) never arrived in %s", exp_q.size(), what));
	endtask

	task automatic cold_read_reuse();
		int lr;
		lr = line_reads;
		issue(1'b0, 64'h0000_1040, '0, '0);
		drain("cold read");
		check("line reads after cold read", 64'(lr + 1), 64'(line_reads));
		issue(1'b0, 64'h0000_1048, '0, '0); // other half of the line.
		issue(1'b0, 64'h0000_1040, '0, '0);
		drain("reread");
		check("line reads after reread", 64'(lr + 1), 64'(line_reads));
	endtask

	task automatic write_through_merge();
		int lr;
		issue(1'b1, 64'h0000_1048, 64'h1122_3344_5566_7788, 8'h0f);
		drain("write hit");
		check("mem write flag", 64'd1, 64'(last_mem_req.write));
		check("mem write addr", 64'h0000_1048, last_mem_req.addr);
		check("mem write data", 64'h1122_3344_5566_7788, last_mem_req.wdata);
		check("mem write strobe", 64'h0f, 64'(last_mem_req.strb));
		lr = line_reads;
		issue(1'b0, 64'h0000_1048, '0, '0);
		drain("read after write hit");
		check("line reads after merged read", 64'(lr), 64'(line_reads));
		issue(1'b1, 64'h0000_2050, 64'hdead_beef_cafe_f00d, 8'hff);
		drain("write miss");
		issue(1'b0, 64'h0000_2050, '0, '0);
		drain("read after write miss");
		check("line reads after write miss", 64'(lr + 1), 64'(line_reads));
	endtask

	task automatic device_bypass();
		int lr;
		lr = line_reads;
		issue(1'b0, 64'h9000_0100, '0, '0);
		issue(1'b0, 64'h0000_3060, '0, '0);
		drain("device and cached reads");
		check("line reads before backdoor", 64'(lr + 2), 64'(line_reads));
		backdoor_write(64'h9000_0100, 64'h0bad_0bad_0bad_0bad);
		backdoor_write(64'h0000_3060, 64'h7777_6666_5555_4444);
		ref_store(64'h9000_0100, 64'h0bad_0bad_0bad_0bad, 8'hff); // device always sees memory.
		issue(1'b0, 64'h9000_0100, '0, '0);
		issue(1'b0, 64'h0000_3060, '0, '0); // resident line keeps the old word.
		drain("reads after backdoor");
		check("line reads after backdoor", 64'(lr + 3), 64'(line_reads));
	endtask

	task automatic victim_rotation();
		logic [63:0] line_addr [5];
		int lr;
		for (int k = 0; k < 5; k++)
			line_addr[k] = 64'h0001_0090 + 64'(k) * 64'h400; // all in set 9.
		lr = line_reads;
		for (int k = 0; k < 5; k++)
			issue(1'b0, line_addr[k], '0, '0);
		drain("five reads to one set");
		check("line reads for five lines", 64'(lr + 5), 64'(line_reads));
		issue(1'b0, line_addr[1], '0, '0);
		drain("reread of second line");
		check("line reads, second line resident", 64'(lr + 5), 64'(line_reads));
		issue(1'b0, line_addr[0], '0, '0);
		drain("reread of first line");
		check("line reads, first line evicted", 64'(lr + 6), 64'(line_reads));
	endtask

	task automatic random_stream();
		logic [63:0] addr;
		logic [63:0] wdata;
		logic [7:0] strb;
		logic wr;
		int c0;
		int r_tag;
		int r_set;
		c0 = credits_returned;
		for (int i = 0; i < 40; i++) begin
			r_tag = {$random(seed)} % 6;
			r_set = 1 + {$random(seed)} % 3;
			addr = (64'(8'h40 + r_tag) << 10) | (64'(r_set) << 4);
			addr[3] = 1'($random(seed));
			if ({$random(seed)} % 5 == 0)
				addr = 64'h9000_0000 + 64'({$random(seed)} % 4) * 8;
			wr = ({$random(seed)} % 3 == 0);
			wdata[31:0] = $random(seed);
			wdata[63:32] = $random(seed);
			strb = 8'($random(seed));
			issue(wr, addr, wdata, strb);
		end
		drain("random stream");
		check("credits returned", 64'd40, 64'(credits_returned - c0));
		check("credits held", 64'(`DCACHE_REQ_CREDITS), 64'(credits));
	endtask

	initial begin
		seed = 32'h1db3;
		mem_seed = $random(seed);
		rst = 1'b1;
		req_valid = 1'b0;
		req = '0;
		mem_req_ready = 1'b0;
		mem_rsp_valid = 1'b0;
		mem_rsp_line = '0;
		credits = `DCACHE_REQ_CREDITS;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		cold_read_reuse();
		write_through_merge();
		device_bypass();
		victim_rotation();
		random_stream();
		repeat (4) @(posedge clk);
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

//--- verilog.f
+incdir+include
design/dcache_pkg.sv
design/dcache_tag_lookup.sv
design/dcache_line_access.sv
design/dcache_response.sv
design/dcache_top.sv
verification/dcache_assertions.sv
verification/dcache_tb.sv
